/* common/switch_pkg.sv */
/*
 * Emesh packet types shared by the switch blocks.
 * A packet is 104 bits: srcaddr sits in the top bits and the write bit is bit 0.
 * The address decode assumes a 12/4/16 split into chip ID, group and offset.
 */
package switch_pkg;

   // ##########################################################
   // Widths and constants
   // ##########################################################

   localparam int AW = 32;                    // Address and data width
   localparam int PW = 2*AW+40;               // Full packet width, 104
   localparam logic [3:0] EGROUP_CFG = 4'h0;  // Group of the config space

   // ##########################################################
   // Destination address
   // ##########################################################

   // One address word, seen flat or split into its routing fields
   typedef union packed {
      logic [AW-1:0] flat;                    // Whole address
      struct packed {
         logic [11:0] chip_id;                // Bits 31:20, target chip
         logic [3:0]  group;                  // Bits 19:16, group in chip
         logic [15:0] offset;                 // Bits 15:0, offset in group
      } fields;
   } emesh_addr_t;

   // ##########################################################
   // Packet and request
   // ##########################################################

   typedef struct packed {
      logic [AW-1:0] srcaddr;                 // Return address of the sender
      logic [AW-1:0] data;                    // Write data or read tag
      emesh_addr_t   dstaddr;                 // Routed on this
      logic [4:0]    ctrlmode;                // Passed through untouched
      logic [1:0]    datamode;                // Transfer size code
      logic          write;                   // 1 for write, 0 for read
   } emesh_pkt_t;

   // Request toward one port; wait travels back on its own wire
   typedef struct packed {
      logic       access;                     // Packet valid this cycle
      emesh_pkt_t pkt;                        // Held while wait is high
   } emesh_req_t;

endpackage

/* rtl/channel_steer.sv */
/*
 * Steers one input channel to the register port or the MIO port.
 * Purely combinational. The channel wait follows the wait of the
 * chosen port only, so a busy idle port never stalls the channel.
 */
`timescale 1ns/1ps

module channel_steer #(
   parameter logic [11:0] CHIP_ID  = 12'h7FD,  // Local chip ID, addr[31:20]
   parameter logic [11:0] REMAP_ID = 12'h3E0   // Chip ID put on MIO traffic
) (
   input  switch_pkg::emesh_req_t req_in,      // Incoming channel
   output logic                   wait_out,    // Stall back to the channel
   output switch_pkg::emesh_req_t reg_req,     // Toward register arbiter
   output switch_pkg::emesh_req_t mio_req,     // Toward MIO arbiter
   input  logic                   reg_wait,    // From register arbiter
   input  logic                   mio_wait     // From MIO arbiter
);

   // ##########################################################
   // Destination decode
   // ##########################################################

   logic                   id_hit;             // Addressed to this chip
   logic                   grp_hit;            // Config group selected
   logic                   reg_match;          // Goes to register port
   switch_pkg::emesh_pkt_t remap_pkt;          // MIO copy of the packet

   assign id_hit    = (req_in.pkt.dstaddr.fields.chip_id == CHIP_ID);
   assign grp_hit   = (req_in.pkt.dstaddr.fields.group == switch_pkg::EGROUP_CFG);
   assign reg_match = id_hit & grp_hit;

   // ##########################################################
   // Address remap
   // ##########################################################

   // Only the chip ID changes; group and offset stay as sent
   always_comb begin
      remap_pkt                        = req_in.pkt;
      remap_pkt.dstaddr.fields.chip_id = REMAP_ID;  // New top 12 bits
   end

   // ##########################################################
   // Request gating
   // ##########################################################

   always_comb begin
      reg_req.access = req_in.access & reg_match;   // Config hits only
      reg_req.pkt    = req_in.pkt;                  // Sent unchanged
   end

   always_comb begin
      mio_req.access = req_in.access & ~reg_match;  // Everything else
      mio_req.pkt    = remap_pkt;                   // Remapped copy
   end

   // Exactly one port sees access, so only its wait matters
   assign wait_out = reg_match ? reg_wait : mio_wait;

endmodule

/* rtl/egress_arbiter.sv */
/*
 * Fixed priority arbiter for one output port; input 0 always wins.
 * One-entry output register, refilled in the cycle it drains.
 * Input to output latency is one cycle when the port is idle.
 */
`timescale 1ns/1ps

module egress_arbiter (
   input  logic                   sys_clk,     // System clock
   input  logic                   rst,         // Sync reset, active high
   input  switch_pkg::emesh_req_t req0,        // Write channel, high priority
   input  switch_pkg::emesh_req_t req1,        // Read channel
   output logic                   wait0,       // Stall to input 0
   output logic                   wait1,       // Stall to input 1
   output switch_pkg::emesh_req_t req_out,     // Registered output
   input  logic                   out_wait     // Stall from the port
);

   // ##########################################################
   // Arbitration
   // ##########################################################

   logic                      can_take;        // Register free this cycle
   logic                      grant0;          // Input 0 transfers
   logic                      grant1;          // Input 1 transfers
   logic                      load;            // Any transfer this cycle
   switch_pkg::emesh_pkt_t    sel_pkt;         // Winner's packet
   logic                      out_valid;       // Output register full
   logic [switch_pkg::PW-1:0] out_pkt;         // Output payload

   // Empty, or draining now because the port takes the held packet
   assign can_take = ~out_valid | ~out_wait;

   assign grant0 = req0.access & can_take;
   assign grant1 = req1.access & ~req0.access & can_take;  // Loses to 0
   assign load   = grant0 | grant1;

   assign sel_pkt = grant0 ? req0.pkt : req1.pkt;

   // Wait may rise without access; the producers ignore it then
   assign wait0 = ~can_take;
   assign wait1 = ~can_take | req0.access;     // Full or outranked

   // ##########################################################
   // Output register
   // ##########################################################

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         out_valid <= 1'b0;                    // Port idle after reset
      end else if (can_take) begin
         out_valid <= load;                    // Refill or go empty
      end
   end

   // Payload only moves on a transfer, so it holds under wait
   always_ff @(posedge sys_clk) begin
      if (load) begin
         out_pkt <= sel_pkt;
      end
   end

   always_comb begin
      req_out.access = out_valid;
      req_out.pkt    = switch_pkg::emesh_pkt_t'(out_pkt);
   end

endmodule

/* rtl/mio_switch.sv */
/*
 * Switchboard top: write and read channels in, register and MIO ports out.
 * Config space hits of CHIP_ID go to the register port as sent.
 * All other packets leave on MIO with addr[31:20] set to REMAP_ID.
 */
`timescale 1ns/1ps

module mio_switch #(
   parameter logic [11:0] CHIP_ID  = 12'h7FD,  // Local chip ID
   parameter logic [11:0] REMAP_ID = 12'h3E0   // Outgoing MIO chip ID
) (
   input  logic                   sys_clk,       // System clock
   input  logic                   rst,           // Sync reset, active high
   input  switch_pkg::emesh_req_t wr_in,         // Write channel
   input  switch_pkg::emesh_req_t rd_in,         // Read channel
   output logic                   wr_wait,       // Stall to write channel
   output logic                   rd_wait,       // Stall to read channel
   output switch_pkg::emesh_req_t reg_out,       // Register port
   output switch_pkg::emesh_req_t mio_out,       // MIO port
   input  logic                   reg_out_wait,  // Register port stall
   input  logic                   mio_out_wait   // MIO port stall
);

   // ##########################################################
   // Channel steering
   // ##########################################################

   switch_pkg::emesh_req_t wr_reg_req;           // Write to register port
   switch_pkg::emesh_req_t wr_mio_req;           // Write to MIO port
   switch_pkg::emesh_req_t rd_reg_req;           // Read to register port
   switch_pkg::emesh_req_t rd_mio_req;           // Read to MIO port
   logic                   wr_reg_wait;
   logic                   wr_mio_wait;
   logic                   rd_reg_wait;
   logic                   rd_mio_wait;

   channel_steer #(.CHIP_ID(CHIP_ID), .REMAP_ID(REMAP_ID)) wr_steer (
      .req_in   (wr_in),
      .wait_out (wr_wait),
      .reg_req  (wr_reg_req),
      .mio_req  (wr_mio_req),
      .reg_wait (wr_reg_wait),
      .mio_wait (wr_mio_wait)
   );

   channel_steer #(.CHIP_ID(CHIP_ID), .REMAP_ID(REMAP_ID)) rd_steer (
      .req_in   (rd_in),
      .wait_out (rd_wait),
      .reg_req  (rd_reg_req),
      .mio_req  (rd_mio_req),
      .reg_wait (rd_reg_wait),
      .mio_wait (rd_mio_wait)
   );

   // ##########################################################
   // Output arbiters, write channel on input 0
   // ##########################################################

   egress_arbiter reg_arb (
      .sys_clk  (sys_clk),
      .rst      (rst),
      .req0     (wr_reg_req),
      .req1     (rd_reg_req),
      .wait0    (wr_reg_wait),
      .wait1    (rd_reg_wait),
      .req_out  (reg_out),
      .out_wait (reg_out_wait)
   );

   egress_arbiter mio_arb (
      .sys_clk  (sys_clk),
      .rst      (rst),
      .req0     (wr_mio_req),
      .req1     (rd_mio_req),
      .wait0    (wr_mio_wait),
      .wait1    (rd_mio_wait),
      .req_out  (mio_out),
      .out_wait (mio_out_wait)
   );

endmodule

/* verif/mio_switch_asserts.sv */
/*
 * Handshake checks bound into the switch top.
 * A stalled output keeps access and packet; reset empties both ports.
 */
`timescale 1ns/1ps

module mio_switch_asserts (
   input logic                   sys_clk,
   input logic                   rst,
   input switch_pkg::emesh_req_t reg_out,
   input switch_pkg::emesh_req_t mio_out,
   input logic                   reg_out_wait,
   input logic                   mio_out_wait
);

   reg_hold: assert property (@(posedge sys_clk) disable iff (rst)
      (reg_out.access && reg_out_wait) |=> (reg_out.access && $stable(reg_out.pkt)))
      else $error("reg_out changed while reg_out_wait was high");

   mio_hold: assert property (@(posedge sys_clk) disable iff (rst)
      (mio_out.access && mio_out_wait) |=> (mio_out.access && $stable(mio_out.pkt)))
      else $error("mio_out changed while mio_out_wait was high");

   reg_reset: assert property (@(posedge sys_clk) rst |=> !reg_out.access)
      else $error("reg_out.access high after a reset cycle");

   mio_reset: assert property (@(posedge sys_clk) rst |=> !mio_out.access)
      else $error("mio_out.access high after a reset cycle");

endmodule

bind mio_switch mio_switch_asserts asserts_i (
   .sys_clk      (sys_clk),
   .rst          (rst),
   .reg_out      (reg_out),
   .mio_out      (mio_out),
   .reg_out_wait (reg_out_wait),
   .mio_out_wait (mio_out_wait)
);

/* verif/tb_clkgen.sv */
/*
 * Clock and reset for the switch testbench.
 * Reset is released 1 ns after the fourth rising edge.
 */
`timescale 1ns/1ps

module tb_clkgen (
   output logic sys_clk,                       // 20 ns period
   output logic rst                            // Sync reset, active high
);

   initial begin
      sys_clk = 1'b0;
      forever #10 sys_clk = ~sys_clk;          // Half period
   end

   initial begin
      rst = 1'b1;
      repeat (4) @(posedge sys_clk);           // Four reset cycles
      #1;
      rst = 1'b0;
   end

endmodule

/* verif/tb_checker.sv */
/*
 * Scoreboard for the switch. Samples on the falling edge, where all
 * DUT signals are settled. A transfer is access high with wait low.
 * Queue index is port*2 + source; port 0 reg, 1 mio; source 0 write, 1 read.
 */
`timescale 1ns/1ps

module tb_checker #(
   parameter logic [11:0] CHIP_ID  = 12'h7FD,
   parameter logic [11:0] REMAP_ID = 12'h3E0
) (
   input  logic                   sys_clk,
   input  logic                   rst,
   input  switch_pkg::emesh_req_t wr_in,
   input  switch_pkg::emesh_req_t rd_in,
   input  logic                   wr_wait,
   input  logic                   rd_wait,
   input  switch_pkg::emesh_req_t reg_out,
   input  switch_pkg::emesh_req_t mio_out,
   input  logic                   reg_out_wait,
   input  logic                   mio_out_wait,
   output int                     value_errs,   // Wrong packet contents
   output int                     proto_errs,   // Handshake and order faults
   output int                     leftover      // Packets still expected
);

   switch_pkg::emesh_pkt_t exp_q [4][$];        // Expected per port and source
   switch_pkg::emesh_pkt_t hold_pkt [2];        // Output seen under wait
   switch_pkg::emesh_pkt_t next_pkt [2];        // Due on output next cycle
   logic                   hold_v [2];
   logic                   next_v [2];
   logic                   port_full [2];       // Modeled output register state
   logic                   seen_in;             // Any input transfer yet

   // Config space of the local chip, group 0
   function automatic logic goes_to_reg(input switch_pkg::emesh_pkt_t pkt);
      return (pkt.dstaddr.flat[31:20] == CHIP_ID) && (pkt.dstaddr.flat[19:16] == 4'h0);
   endfunction

   function automatic switch_pkg::emesh_pkt_t remap(input switch_pkg::emesh_pkt_t pkt);
      switch_pkg::emesh_pkt_t res;
      res = pkt;
      res.dstaddr.flat[31:20] = REMAP_ID;       // Top 12 bits replaced
      return res;
   endfunction

   task automatic value_error(input string name, input switch_pkg::emesh_pkt_t want,
                              input switch_pkg::emesh_pkt_t got);
      value_errs++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, want, got);
   endtask

   task automatic wait_error(input string name, input logic want, input logic got);
      value_errs++;
      $display("** Error at %0t: %s expected %b, got %b", $time, name, want, got);
   endtask

   task automatic plain_error(input string what);
      proto_errs++;
      $display("Error at %0t: %s", $time, what);
   endtask

   // ##########################################################
   // Falling edge scoreboard
   // ##########################################################

   always @(negedge sys_clk) begin
      switch_pkg::emesh_req_t outs [2];
      switch_pkg::emesh_req_t ins [2];
      logic                   out_wait [2];
      logic                   in_wait [2];
      switch_pkg::emesh_pkt_t want;
      string                  pname;
      logic                   exp_wait;
      int                     tgt [2];
      int                     idx;
      int                     p;
      outs[0]     = reg_out;
      outs[1]     = mio_out;
      out_wait[0] = reg_out_wait;
      out_wait[1] = mio_out_wait;
      ins[0]      = wr_in;
      ins[1]      = rd_in;
      in_wait[0]  = wr_wait;
      in_wait[1]  = rd_wait;
      if (rst) begin
         value_errs = 0;
         proto_errs = 0;
         seen_in    = 1'b0;
         for (int i = 0; i < 4; i++) exp_q[i].delete();
         for (int i = 0; i < 2; i++) begin
            hold_v[i]    = 1'b0;
            next_v[i]    = 1'b0;
            port_full[i] = 1'b0;
         end
      end else begin
         for (int i = 0; i < 2; i++) begin
            pname = (i == 0) ? "reg_out.pkt" : "mio_out.pkt";
            if (next_v[i] && !outs[i].access) begin
               plain_error($sformatf("%s did not appear one cycle after its transfer", pname));
            end else if (next_v[i] && outs[i].pkt != next_pkt[i]) begin
               value_error(pname, next_pkt[i], outs[i].pkt);  // Latency check
            end
            if (hold_v[i] && !outs[i].access) begin
               plain_error($sformatf("%s dropped access while its wait was high", pname));
            end else if (hold_v[i] && outs[i].pkt != hold_pkt[i]) begin
               value_error(pname, hold_pkt[i], outs[i].pkt);  // Changed under wait
            end
            if (!seen_in && outs[i].access) begin
               plain_error($sformatf("%s access high after reset with no input", pname));
            end
            if (outs[i].access && !out_wait[i]) begin
               idx = i*2 + (outs[i].pkt.write ? 0 : 1);     // Source from write bit
               if (exp_q[idx].size() == 0) begin
                  plain_error($sformatf("%s delivered a packet nobody sent", pname));
               end else begin
                  want = exp_q[idx].pop_front();
                  if (outs[i].pkt != want) value_error(pname, want, outs[i].pkt);
               end
            end
            hold_v[i]   = outs[i].access && out_wait[i];
            hold_pkt[i] = outs[i].pkt;
            next_v[i]   = 1'b0;
         end
         // Expected channel waits from the modeled port state
         for (int c = 0; c < 2; c++) begin
            tgt[c] = goes_to_reg(ins[c].pkt) ? 0 : 1;
         end
         for (int c = 0; c < 2; c++) begin
            exp_wait = port_full[tgt[c]] && out_wait[tgt[c]];  // Port cannot take
            if (c == 1 && ins[0].access && tgt[0] == tgt[1]) begin
               exp_wait = 1'b1;                                // Write channel wins
            end
            if (ins[c].access && in_wait[c] != exp_wait) begin
               wait_error((c == 0) ? "wr_wait" : "rd_wait", exp_wait, in_wait[c]);
            end
         end
         // Model of the routing; registered one cycle later
         for (int c = 0; c < 2; c++) begin
            if (ins[c].access && !in_wait[c]) begin
               seen_in = 1'b1;
               p       = tgt[c];
               want    = (p == 0) ? ins[c].pkt : remap(ins[c].pkt);
               exp_q[p*2 + c].push_back(want);
               next_v[p]   = 1'b1;
               next_pkt[p] = want;
            end
         end
         for (int i = 0; i < 2; i++) begin
            port_full[i] = (port_full[i] && out_wait[i]) || next_v[i];  // Held or refilled
         end
      end
      leftover = exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size();
   end

endmodule

/* verif/tb_top.sv */
/*
 * Random traffic on both switch channels with random output stalls.
 * Inputs change 1 ns after the rising edge; the checker samples on the falling edge.
 * Write channel packets carry write=1, read channel packets write=0.
 */
`timescale 1ns/1ps

module tb_top;

   localparam logic [11:0] CHIP_ID  = 12'h7FD;
   localparam logic [11:0] REMAP_ID = 12'h3E0;
   localparam int          NUM_PKTS = 500;        // Per channel
   localparam int          TIMEOUT  = 1000;       // Cycles per wait loop

   logic                   sys_clk;
   logic                   rst;
   switch_pkg::emesh_req_t wr_in;
   switch_pkg::emesh_req_t rd_in;
   switch_pkg::emesh_req_t reg_out;
   switch_pkg::emesh_req_t mio_out;
   logic                   wr_wait;
   logic                   rd_wait;
   logic                   reg_out_wait;
   logic                   mio_out_wait;
   int                     value_errs;
   int                     proto_errs;
   int                     leftover;
   int                     timeouts = 0;
   logic                   run_done = 1'b0;

   tb_clkgen clkgen_i (.sys_clk(sys_clk), .rst(rst));

   mio_switch dut_i (
      .sys_clk      (sys_clk),
      .rst          (rst),
      .wr_in        (wr_in),
      .rd_in        (rd_in),
      .wr_wait      (wr_wait),
      .rd_wait      (rd_wait),
      .reg_out      (reg_out),
      .mio_out      (mio_out),
      .reg_out_wait (reg_out_wait),
      .mio_out_wait (mio_out_wait)
   );

   tb_checker #(.CHIP_ID(CHIP_ID), .REMAP_ID(REMAP_ID)) chk_i (.*);

   // ##########################################################
   // Stimulus
   // ##########################################################

   function automatic switch_pkg::emesh_pkt_t make_pkt(input logic is_write);
      switch_pkg::emesh_pkt_t pkt;
      logic [31:0]            r;
      r                = $urandom;
      pkt.srcaddr      = $urandom;
      pkt.data         = $urandom;
      pkt.dstaddr.flat = $urandom;
      pkt.ctrlmode     = r[4:0];
      pkt.datamode     = r[6:5];
      pkt.write        = is_write;                // Tags the source
      if (r[7]) begin
         pkt.dstaddr.flat[31:16] = {CHIP_ID, 4'h0};  // Config space hit
      end else if (r[9:8] == 2'b00) begin
         pkt.dstaddr.flat[31:20] = CHIP_ID;          // Local chip, other group
         pkt.dstaddr.flat[19:16] = (r[13:10] == 4'h0) ? 4'h5 : r[13:10];
      end
      return pkt;
   endfunction

   task automatic send_channel(input logic is_write);
      switch_pkg::emesh_req_t req;
      logic                   stall;
      int                     cycles;
      for (int n = 0; n < NUM_PKTS; n++) begin
         req.access = 1'b1;
         req.pkt    = make_pkt(is_write);
         if (is_write) wr_in = req;
         else          rd_in = req;
         stall  = 1'b1;
         cycles = 0;
         while (stall && cycles < TIMEOUT) begin
            @(negedge sys_clk);
            stall = is_write ? wr_wait : rd_wait;  // Transfer at next edge if low
            cycles++;
         end
         @(posedge sys_clk);
         #1;
         if (stall) begin
            timeouts++;
            $display("Timeout: %s channel stalled for %0d cycles", is_write ? "write" : "read",
                     TIMEOUT);
            break;
         end
         if (($urandom & 32'h3) == 32'h0) begin   // Occasional idle cycle
            req.access = 1'b0;
            if (is_write) wr_in = req;
            else          rd_in = req;
            @(posedge sys_clk);
            #1;
         end
      end
      req.access = 1'b0;
      if (is_write) wr_in = req;
      else          rd_in = req;
   endtask

   // Random output back-pressure, about one cycle in four
   task automatic drive_out_waits();
      logic [31:0] r;
      while (!run_done) begin
         @(posedge sys_clk);
         #1;
         r            = $urandom;
         reg_out_wait = (r[1:0] == 2'b00);
         mio_out_wait = (r[3:2] == 2'b00);
      end
   endtask

   // ##########################################################
   // Run control
   // ##########################################################

   initial begin
      int cycles;
      void'($urandom(32'h9f48528d));
      wr_in        = '0;
      rd_in        = '0;
      reg_out_wait = 1'b0;
      mio_out_wait = 1'b0;
      cycles       = 0;
      fork
         drive_out_waits();
      join_none
      while (rst !== 1'b0 && cycles < TIMEOUT) begin
         @(negedge sys_clk);
         cycles++;
      end
      if (rst !== 1'b0) begin
         timeouts++;
         $display("Timeout: reset never released");
      end else begin
         repeat (5) @(posedge sys_clk);            // Idle ports after reset
         #1;
         fork
            send_channel(1'b1);
            send_channel(1'b0);
         join
         cycles = 0;
         while (leftover != 0 && cycles < TIMEOUT) begin
            @(posedge sys_clk);
            cycles++;
         end
         if (leftover != 0) begin
            timeouts++;
            $display("Timeout: %0d packets never left the switch", leftover);
         end
         repeat (3) @(posedge sys_clk);
      end
      run_done = 1'b1;
      $display("Error counts: value %0d, protocol %0d, timeout %0d, left in queues %0d",
               value_errs, proto_errs, timeouts, leftover);
      if (value_errs + proto_errs + timeouts + leftover == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* tb.f */
common/switch_pkg.sv
rtl/channel_steer.sv
rtl/egress_arbiter.sv
rtl/mio_switch.sv
verif/mio_switch_asserts.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the switch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

# A run that aborts early never prints the pass line
if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then
   echo "Run FAILED, see sim.log"
   exit 1
fi
echo "Run OK"
